//--- tests/fractalRenderer_vectors.txt
# cornerX cornerY zoom colourSum interiorCount
# corners are Q4.32 in hex, zoom in hex, sum and count in decimal
100000000 000000000 0 192 0
100000000 000000000 3 192 0
1F0000000 000000000 0 96 0
1F0000000 000000000 1 192 0
1F0000000 000000000 2 192 0
000000000 20A000000 0 96 0
FF0000000 010000000 0 1344 192

//--- fractalRenderer.f
+incdir+design
design/fixedPointPkg.sv
design/pixelPkg.sv
design/pixelIfc.sv
design/coordGenerator.sv
design/mandelbrotCore.sv
design/resultArbiter.sv
design/fractalRenderer.sv
tests/fractalRenderer_chk.sv
tests/fractalRenderer_tb.sv

//--- Bender.yml
package:
  name: fractalRenderer

export_include_dirs:
  - design

sources:
  - files:
      - design/fixedPointPkg.sv
      - design/pixelPkg.sv
      - design/pixelIfc.sv
      - design/coordGenerator.sv
      - design/mandelbrotCore.sv
      - design/resultArbiter.sv
      - design/fractalRenderer.sv
  - target: test
    files:
      - tests/fractalRenderer_chk.sv
      - tests/fractalRenderer_tb.sv

//--- tests/fractalRenderer_tb.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

module fractalRenderer_tb
  import fixedPointPkg::*, pixelPkg::*;
();

  localparam int frameWidth  = 16;
  localparam int frameHeight = 12;
  localparam int pixelCount  = frameWidth * frameHeight;
  localparam int doneTimeout = 250000;   // Interior frame needs about 97k cycles
  localparam int dropTimeout = 8;

  logic                  CLOCK_50, reset, draw;
  fixedT                 upperLeftX, upperLeftY;
  logic [`ZOOM_BITS-1:0] zoomLevel;
  logic                  pixelWrite, done;
  pixelAddrT             pixelAddr;
  colorT                 pixelColor;

  // One entry per vectors line
  fixedT                 vecX[$], vecY[$];
  logic [`ZOOM_BITS-1:0] vecZoom[$];
  int                    vecSum[$], vecInterior[$];
  int                    firstSum[$], firstInterior[$];   // Results of the first pass

  bit          expectWrites, farCheck, aborted;
  colorT       farColor;
  int          writeCount, colorSum, interiorCount;
  int          hits[pixelCount];   // Writes per address
  int          valueErrors, monitorErrors, otherErrors;
  logic [31:0] lfsr;

  fractalRenderer #(
    .frameWidth (frameWidth),
    .frameHeight(frameHeight)
  ) fractalRenderer_i (
    .CLOCK_50  (CLOCK_50),
    .reset     (reset),
    .draw      (draw),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .zoomLevel (zoomLevel),
    .pixelWrite(pixelWrite),
    .pixelAddr (pixelAddr),
    .pixelColor(pixelColor),
    .done      (done)
  );

  always #50 CLOCK_50 = ~CLOCK_50;   // 100 ns period

  ////////////////////
  // Helpers
  ////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic nextGap(output int gap);
    gap = 0;
    repeat (4) begin
      lfsr = lfsrNext(lfsr);
      gap  = (gap << 1) | lfsr[0];   // One step per bit
    end
  endtask

  // 7 at the limit, else floor of log2 capped at 6
  function automatic colorT colorFromCount(int n);
    int level;
    level = 0;
    if (n >= `MAX_ITER) return colorT'(7);
    while (n > 1) begin
      n = n / 2;
      level++;
    end
    return colorT'((level > 6) ? 6 : level);
  endfunction

  task automatic compareValue(string what, int got, int expected);
    if (got != expected) begin
      valueErrors++;
      $display("Error: %s is %h, expected %h", what, got, expected);
    end
  endtask

  task automatic loadVectors;
    int                    fd, code, s, c;
    string                 line;
    fixedT                 x, y;
    logic [`ZOOM_BITS-1:0] z;
    fd = $fopen("tests/fractalRenderer_vectors.txt", "r");
    if (fd == 0) begin
      otherErrors++;
      $display("Could not open the vectors file");
      aborted = 1'b1;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin   // Skip comments
        if ($sscanf(line, "%h %h %h %d %d", x, y, z, s, c) == 5) begin
          vecX.push_back(x);
          vecY.push_back(y);
          vecZoom.push_back(z);
          vecSum.push_back(s);
          vecInterior.push_back(c);
        end
      end
    end
    $fclose(fd);
    if (vecX.size() == 0) begin
      otherErrors++;
      $display("The vectors file holds no frames");
      aborted = 1'b1;
    end
  endtask

  // Between frames done must hold and nothing is written
  task automatic idleGap(int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge CLOCK_50);
      if (done !== 1'b1) begin
        otherErrors++;
        $display("done dropped while no frame was requested");
      end
    end
  endtask

  task automatic runFrame(fixedT x, fixedT y, logic [`ZOOM_BITS-1:0] zoom, bit far,
                          output int sum, output int interior);
    int cycles;
    @(posedge CLOCK_50);
    draw          <= 1'b1;   // Held for the whole frame
    upperLeftX    <= x;
    upperLeftY    <= y;
    zoomLevel     <= zoom;
    writeCount    = 0;
    colorSum      = 0;
    interiorCount = 0;
    farCheck      = far;
    expectWrites  = 1'b1;
    foreach (hits[a]) hits[a] = 0;
    cycles = 0;
    do begin   // Old done clears once draw is taken
      @(negedge CLOCK_50);
      cycles++;
    end while (done !== 1'b0 && cycles < dropTimeout);
    if (done !== 1'b0) begin
      otherErrors++;
      $display("done did not drop after draw");
      aborted = 1'b1;
    end
    cycles = 0;
    while (!aborted && done !== 1'b1 && cycles < doneTimeout) begin
      @(negedge CLOCK_50);
      cycles++;
    end
    if (!aborted && done !== 1'b1) begin
      otherErrors++;
      $display("Timed out after %0d cycles waiting for done", cycles);
      aborted = 1'b1;
    end
    @(posedge CLOCK_50);
    draw         <= 1'b0;
    expectWrites = 1'b0;
    farCheck     = 1'b0;
    if (!aborted) begin
      compareValue("pixelWrite count", writeCount, pixelCount);
      foreach (hits[a]) begin
        if (hits[a] != 1) begin
          valueErrors++;
          $display("Error: pixelAddr %h written %h times, expected 1", a, hits[a]);
        end
      end
    end
    sum      = colorSum;
    interior = interiorCount;
  endtask

  task automatic finishRun;
    int assertFails;
    assertFails = fractalRenderer_i.portChecks.writeDoneFails
                + fractalRenderer_i.portChecks.addrFails
                + fractalRenderer_i.portChecks.holdFails
                + fractalRenderer_i.portChecks.overlapFails;
    $display("Value errors %0d, monitor errors %0d, other errors %0d, assertion failures %0d",
             valueErrors, monitorErrors, otherErrors, assertFails);
    if (valueErrors + monitorErrors + otherErrors + assertFails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  ////////////////////
  // Write monitor
  ////////////////////

  always @(negedge CLOCK_50) begin
    if (pixelWrite === 1'b1) begin
      if (!expectWrites) begin
        monitorErrors++;
        $display("Pixel write seen outside a frame");
      end
      writeCount++;
      colorSum += pixelColor;
      if (pixelColor == colorT'(7)) interiorCount++;   // Interior pixel
      if (pixelAddr < pixelCount) begin
        hits[pixelAddr]++;
      end else begin
        monitorErrors++;
        $display("Error: pixelAddr is %h, expected below %h", pixelAddr, pixelCount);
      end
      if (farCheck && pixelColor !== farColor) begin
        monitorErrors++;
        $display("Error: pixelColor at %h is %h, expected %h", pixelAddr, pixelColor, farColor);
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int gap, sum, interior;
    CLOCK_50      = 1'b0;
    reset         = 1'b1;
    draw          = 1'b0;
    upperLeftX    = '0;
    upperLeftY    = '0;
    zoomLevel     = '0;
    lfsr          = 32'hc0598e27;
    valueErrors   = 0;
    monitorErrors = 0;
    otherErrors   = 0;
    expectWrites  = 1'b0;
    farCheck      = 1'b0;
    aborted       = 1'b0;
    farColor      = colorFromCount(1);   // Corner at 6 escapes after one step
    loadVectors();

    // Reset, then a few idle cycles before the first draw
    for (int i = 0; i < 20; i++) begin
      @(posedge CLOCK_50);
      if (i == 15) reset <= 1'b0;
      @(negedge CLOCK_50);
      if (pixelWrite !== 1'b0 || done !== 1'b0) begin
        otherErrors++;
        $display("pixelWrite or done not low before the first draw");
      end
    end

    // First pass, frames back to back
    for (int k = 0; k < vecX.size() && !aborted; k++) begin
      runFrame(vecX[k], vecY[k], vecZoom[k], 1'b0, sum, interior);
      compareValue("pixelColor sum", sum, vecSum[k]);
      compareValue("pixelColor 7 count", interior, vecInterior[k]);
      firstSum.push_back(sum);
      firstInterior.push_back(interior);
    end

    // Window far right of the set
    if (!aborted) begin
      runFrame(fixedT'(36'h600000000), '0, '0, 1'b1, sum, interior);
      compareValue("pixelColor sum", sum, pixelCount * int'(farColor));
      compareValue("pixelColor 7 count", interior, 0);
    end

    // Repeat with random idle gaps
    for (int k = 0; k < vecX.size() && !aborted; k++) begin
      nextGap(gap);
      idleGap(gap);
      runFrame(vecX[k], vecY[k], vecZoom[k], 1'b0, sum, interior);
      compareValue("pixelColor sum", sum, vecSum[k]);
      compareValue("pixelColor 7 count", interior, vecInterior[k]);
      compareValue("pixelColor sum on repeat", sum, firstSum[k]);
      compareValue("pixelColor 7 count on repeat", interior, firstInterior[k]);
    end

    finishRun();
  end

endmodule

//--- tests/fractalRenderer_chk.sv
`timescale 1ns/1ps

module fractalRenderer_chk
  import pixelPkg::*;
#(
  parameter int pixelCount = 192
) (
  input  logic      CLOCK_50,
  input  logic      reset,
  input  logic      frameStart,
  input  logic      pixelWrite,
  input  pixelAddrT pixelAddr,
  input  logic      done,
  pixelJobIf        job0,
  pixelJobIf        job1
);

  // Failure tallies, one per assertion
  int writeDoneFails = 0;
  int addrFails      = 0;
  int holdFails      = 0;
  int overlapFails   = 0;

  logic jobTaken;   // Either core accepts the pending job

  assign jobTaken = (job0.jobValid && job0.coreReady) || (job1.jobValid && job1.coreReady);

  ////////////////////
  // Output stream
  ////////////////////

  writeNotDone: assert property (@(posedge CLOCK_50) disable iff (reset)
    !(pixelWrite && done)) else begin
      $error("pixelWrite and done high in the same cycle");
      writeDoneFails++;
    end

  addrInFrame: assert property (@(posedge CLOCK_50) disable iff (reset)
    pixelWrite |-> (pixelAddr < pixelCount)) else begin
      $error("pixelAddr %h outside the frame", pixelAddr);
      addrFails++;
    end

  ////////////////////
  // Job handshake
  ////////////////////

  // Pending job stays put until a core takes it
  holdJob: assert property (@(posedge CLOCK_50) disable iff (reset)
    !frameStart && !jobTaken && !$isunknown(job0.jobAddr)
      |=> $stable(job0.jobAddr) && $stable(job1.jobAddr)
          && $stable(job0.jobX) && $stable(job0.jobY)) else begin
      $error("Pending job changed before a core took it");
      holdFails++;
    end

  oneJobAtATime: assert property (@(posedge CLOCK_50) disable iff (reset)
    !(job0.jobValid && job1.jobValid)) else begin
      $error("Both cores offered a job in one cycle");
      overlapFails++;
    end

endmodule

bind fractalRenderer fractalRenderer_chk #(
  .pixelCount(frameWidth * frameHeight)
) portChecks (
  .CLOCK_50  (CLOCK_50),
  .reset     (reset),
  .frameStart(frameStart),
  .pixelWrite(pixelWrite),
  .pixelAddr (pixelAddr),
  .done      (done),
  .job0      (jobIf0),
  .job1      (jobIf1)
);

//--- design/fractalRenderer.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

module fractalRenderer
  import fixedPointPkg::*, pixelPkg::*;
#(
  parameter int frameWidth  = `FRAME_WIDTH,
  parameter int frameHeight = `FRAME_HEIGHT
) (
  input  logic                  CLOCK_50,
  input  logic                  reset,
  input  logic                  draw,         // Level, sampled while idle
  input  fixedT                 upperLeftX,
  input  fixedT                 upperLeftY,
  input  logic [`ZOOM_BITS-1:0] zoomLevel,
  output logic                  pixelWrite,
  output pixelAddrT             pixelAddr,
  output colorT                 pixelColor,
  output logic                  done
);

  logic frameStart;

  // One job and one result channel per core
  pixelJobIf    jobIf0 ();
  pixelJobIf    jobIf1 ();
  pixelResultIf resIf0 ();
  pixelResultIf resIf1 ();

  coordGenerator #(
    .frameWidth (frameWidth),
    .frameHeight(frameHeight)
  ) coordGen (
    .CLOCK_50  (CLOCK_50),
    .reset     (reset),
    .draw      (draw),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .zoomLevel (zoomLevel),
    .frameStart(frameStart),
    .job0      (jobIf0),
    .job1      (jobIf1)
  );

  ////////////////////
  // Cores
  ////////////////////

  mandelbrotCore core0 (
    .CLOCK_50(CLOCK_50),
    .reset   (reset),
    .job     (jobIf0),
    .result  (resIf0)
  );

  mandelbrotCore core1 (
    .CLOCK_50(CLOCK_50),
    .reset   (reset),
    .job     (jobIf1),
    .result  (resIf1)
  );

  resultArbiter #(
    .pixelCount(frameWidth * frameHeight)
  ) arbiter (
    .CLOCK_50  (CLOCK_50),
    .reset     (reset),
    .frameStart(frameStart),
    .res0      (resIf0),
    .res1      (resIf1),
    .pixelWrite(pixelWrite),
    .pixelAddr (pixelAddr),
    .pixelColor(pixelColor),
    .done      (done)
  );

endmodule

//--- design/resultArbiter.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

module resultArbiter
  import pixelPkg::*;
#(
  parameter int pixelCount = `FRAME_WIDTH * `FRAME_HEIGHT
) (
  input  logic       CLOCK_50,
  input  logic       reset,
  input  logic       frameStart,
  pixelResultIf.sink res0,
  pixelResultIf.sink res1,
  output logic       pixelWrite,
  output pixelAddrT  pixelAddr,
  output colorT      pixelColor,
  output logic       done
);

  localparam int countBits = $clog2(pixelCount + 1);

  logic                 favorOne;     // Core 1 wins the next tie
  logic                 pick0, pick1;
  logic [countBits-1:0] writeCount;   // Writes since frameStart

  ////////////////////
  // Selection
  ////////////////////

  assign pick0 = res0.resultValid && (!res1.resultValid || !favorOne);
  assign pick1 = res1.resultValid && !pick0;

  // Stored and the write share one cycle
  assign res0.stored = pick0;
  assign res1.stored = pick1;

  assign pixelWrite = pick0 || pick1;
  assign pixelAddr  = pick1 ? res1.resultAddr : res0.resultAddr;
  assign pixelColor = pick1 ? res1.resultColor : res0.resultColor;

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      favorOne <= 1'b0;
    end else if (pick0) begin
      favorOne <= 1'b1;   // Last winner goes to the back
    end else if (pick1) begin
      favorOne <= 1'b0;
    end
  end

  ////////////////////
  // Frame completion
  ////////////////////

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      writeCount <= '0;
      done       <= 1'b0;
    end else if (frameStart) begin
      writeCount <= '0;
      done       <= 1'b0;   // Drops with the accepted draw
    end else if (pixelWrite) begin
      writeCount <= writeCount + 1'b1;
      if (writeCount == countBits'(pixelCount - 1)) begin
        done <= 1'b1;       // Last pixel of the frame
      end
    end
  end

endmodule

//--- design/mandelbrotCore.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

module mandelbrotCore
  import fixedPointPkg::*, pixelPkg::*;
(
  input  logic       CLOCK_50,
  input  logic       reset,
  pixelJobIf.core    job,
  pixelResultIf.core result
);

  localparam int fixedBits = `INT_BITS + `FRAC_BITS;

  typedef enum logic [1:0] {sReady, sIterate, sHold} coreStateT;

  coreStateT                     state;
  fixedT                         cr, ci;       // c of this pixel
  fixedT                         zr, zi;       // Running z
  iterT                          n;
  pixelAddrT                     addr;
  colorT                         color;
  logic signed [2*fixedBits-1:0] prodRR, prodII, prodRI;
  fixedT                         zr2, zi2, zrzi;
  fixedWordU                     zrWord, ziWord, sumWord;
  logic                          bigComponent, bigMagnitude, finished;

  // Integer field magnitude of 2 or more
  function automatic logic atLeastTwo(fixedWordU w);
    return (w.fields.intPart >= 2) || (w.fields.intPart <= -2);
  endfunction

  // 7 at the limit, else floor(log2 n) capped at 6
  function automatic colorT iterToColor(iterT count);
    colorT c;
    c = '0;
    if (count == iterT'(`MAX_ITER)) begin
      c = '1;
    end else begin
      for (int b = 1; b < `ITER_BITS; b++) begin
        if (count[b]) c = (b > 6) ? colorT'(6) : colorT'(b);  // Highest set bit wins
      end
    end
    return c;
  endfunction

  ////////////////////
  // Datapath
  ////////////////////

  assign prodRR = zr * zr;
  assign prodII = zi * zi;
  assign prodRI = zr * zi;

  // Drop the low fraction bits
  assign zr2  = prodRR[`FRAC_BITS +: fixedBits];
  assign zi2  = prodII[`FRAC_BITS +: fixedBits];
  assign zrzi = prodRI[`FRAC_BITS +: fixedBits];

  assign zrWord.raw  = zr;
  assign ziWord.raw  = zi;
  assign sumWord.raw = zr2 + zi2;   // |z|^2, no overflow once both parts are below 2

  assign bigComponent = atLeastTwo(zrWord) || atLeastTwo(ziWord);
  assign bigMagnitude = (sumWord.fields.intPart >= 4);
  assign finished     = bigComponent || bigMagnitude || (n == iterT'(`MAX_ITER));

  assign job.coreReady      = (state == sReady);
  assign result.resultValid = (state == sHold);
  assign result.resultAddr  = addr;
  assign result.resultColor = color;

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state <= sReady;
    end else begin
      case (state)
        sReady:   if (job.jobValid) state <= sIterate;   // Ready is implied here
        sIterate: if (finished) state <= sHold;
        sHold:    if (result.stored) state <= sReady;
        default:  state <= sReady;
      endcase
    end
  end

  always_ff @(posedge CLOCK_50) begin
    case (state)
      sReady: begin
        if (job.jobValid) begin
          cr   <= job.jobX;
          ci   <= job.jobY;
          addr <= job.jobAddr;
          zr   <= '0;          // z starts at zero
          zi   <= '0;
          n    <= '0;
        end
      end
      sIterate: begin
        if (finished) begin
          color <= iterToColor(n);
        end else begin
          zr <= zr2 - zi2 + cr;         // Re(z^2 + c)
          zi <= (zrzi <<< 1) + ci;      // Im(z^2 + c)
          n  <= n + 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

//--- design/coordGenerator.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

module coordGenerator
  import fixedPointPkg::*, pixelPkg::*;
#(
  parameter int frameWidth  = `FRAME_WIDTH,
  parameter int frameHeight = `FRAME_HEIGHT
) (
  input  logic                  CLOCK_50,
  input  logic                  reset,
  input  logic                  draw,
  input  fixedT                 upperLeftX,
  input  fixedT                 upperLeftY,
  input  logic [`ZOOM_BITS-1:0] zoomLevel,
  output logic                  frameStart,
  pixelJobIf.source             job0,
  pixelJobIf.source             job1
);

  localparam int colBits = (frameWidth > 1) ? $clog2(frameWidth) : 1;
  localparam int rowBits = (frameHeight > 1) ? $clog2(frameHeight) : 1;

  typedef enum logic [1:0] {sIdle, sRun, sDrain} genStateT;

  genStateT           state;
  logic [colBits-1:0] col;
  logic [rowBits-1:0] row;
  pixelAddrT          addr;
  fixedT              cornerX;      // Left edge, reloaded each row
  fixedT              curX, curY;   // Coordinate of the pending pixel
  fixedT              step;
  logic               jobTaken, lastPixel;

  assign frameStart = (state == sIdle) && draw;  // Draw accepted this cycle

  // Core 0 gets first pick, core 1 only when core 0 is busy
  assign job0.jobValid = (state == sRun) && job0.coreReady;
  assign job1.jobValid = (state == sRun) && !job0.coreReady && job1.coreReady;

  // Both cores see the same pending job
  assign job0.jobX    = curX;
  assign job0.jobY    = curY;
  assign job0.jobAddr = addr;
  assign job1.jobX    = curX;
  assign job1.jobY    = curY;
  assign job1.jobAddr = addr;

  assign jobTaken  = (job0.jobValid && job0.coreReady) || (job1.jobValid && job1.coreReady);
  assign lastPixel = (col == colBits'(frameWidth - 1)) && (row == rowBits'(frameHeight - 1));

  always_ff @(posedge CLOCK_50) begin
    if (reset) begin
      state <= sIdle;
    end else begin
      case (state)
        sIdle:   if (draw) state <= sRun;
        sRun:    if (jobTaken && lastPixel) state <= sDrain;
        // Wait for both cores to finish the frame
        sDrain:  if (job0.coreReady && job1.coreReady) state <= sIdle;
        default: state <= sIdle;
      endcase
    end
  end

  ////////////////////
  // Raster scan
  ////////////////////

  always_ff @(posedge CLOCK_50) begin
    if (frameStart) begin
      col     <= '0;
      row     <= '0;
      addr    <= '0;
      cornerX <= upperLeftX;
      curX    <= upperLeftX;
      curY    <= upperLeftY;
      step    <= fixedT'(1) << (`FRAC_BITS - `BASE_STEP_SHIFT - zoomLevel);  // 2^-(7+zoom)
    end else if (jobTaken) begin
      addr <= addr + 1'b1;
      if (col == colBits'(frameWidth - 1)) begin
        col  <= '0;
        row  <= row + 1'b1;
        curX <= cornerX;       // Back to left edge
        curY <= curY - step;   // Y grows upward, rows go down
      end else begin
        col  <= col + 1'b1;
        curX <= curX + step;
      end
    end
  end

endmodule

//--- design/pixelIfc.sv
`timescale 1ns/1ps

`include "fractal_cfg.svh"

////////////////////
// Generator to core
////////////////////

interface pixelJobIf import fixedPointPkg::*, pixelPkg::*; ();

  logic      jobValid;   // Job offered
  fixedT     jobX;       // Real part of c
  fixedT     jobY;       // Imaginary part of c
  pixelAddrT jobAddr;    // Where the result goes
  logic      coreReady;  // Core idle

  // Transfer on an edge with jobValid and coreReady both high
  modport source (
    output jobValid, jobX, jobY, jobAddr,
    input  coreReady
  );

  modport core (
    input  jobValid, jobX, jobY, jobAddr,
    output coreReady
  );

endinterface

////////////////////
// Core to arbiter
////////////////////

interface pixelResultIf import pixelPkg::*; ();

  logic      resultValid;  // Colour waiting
  pixelAddrT resultAddr;
  colorT     resultColor;
  logic      stored;       // One-cycle pulse, result written

  modport core (
    output resultValid, resultAddr, resultColor,
    input  stored
  );

  modport sink (
    input  resultValid, resultAddr, resultColor,
    output stored
  );

endinterface

//--- design/pixelPkg.sv
`include "fractal_cfg.svh"

package pixelPkg;

  // Framebuffer address
  // row times frame width plus column
  typedef logic [`ADDR_BITS-1:0] pixelAddrT;

  // Iteration count, wide enough for MAX_ITER
  typedef logic [`ITER_BITS-1:0] iterT;

  // Colour index written to the framebuffer
  // 7 marks an interior pixel
  typedef logic [`COLOR_BITS-1:0] colorT;

endpackage

//--- design/fixedPointPkg.sv
`include "fractal_cfg.svh"

package fixedPointPkg;

  // Raw signed word used for all arithmetic
  typedef logic signed [`INT_BITS+`FRAC_BITS-1:0] fixedT;

  // Same word split at the binary point
  typedef struct packed {
    logic signed [`INT_BITS-1:0] intPart;   // Floor of the value
    logic        [`FRAC_BITS-1:0] fracPart;
  } fixedFieldsT;

  // One word seen two ways
  // raw for add and multiply, fields for escape tests
  typedef union packed {
    fixedT       raw;
    fixedFieldsT fields;
  } fixedWordU;

endpackage

//--- design/fractal_cfg.svh
`ifndef FRACTAL_CFG_SVH
`define FRACTAL_CFG_SVH

////////////////////
// Number format
////////////////////

// Signed Q4.32 fixed point
`define FRAC_BITS 32
`define INT_BITS 4

////////////////////
// Frame and pixel
////////////////////

`define FRAME_WIDTH 640        // Default frame size
`define FRAME_HEIGHT 480
`define ADDR_BITS 19           // Enough for 640 x 480
`define COLOR_BITS 3

// Iteration limit and count width
`define MAX_ITER 1000
`define ITER_BITS 10

// Pixel step at zoom 0 is 2^-7
`define BASE_STEP_SHIFT 7
`define ZOOM_BITS 4

`endif
